/* hdl/glbl_map_pkg.sv */
package glbl_map_pkg;

   // -------------------------------------------------------------------------
   // Bus geometry
   // -------------------------------------------------------------------------
   localparam int DATA_W = 32;
   localparam int ADDR_W = 5;
   localparam int BE_W   = 4;

   // Mask, cfg, reset ctrl, mux select, mailbox and eight scratch words
   localparam int NUM_RW = 13;

   // Register map
   localparam logic [ADDR_W-1:0] ADDR_CHIP_ID   = 5'd0;
   localparam logic [ADDR_W-1:0] ADDR_RST_CTRL  = 5'd1;
   localparam logic [ADDR_W-1:0] ADDR_CFG       = 5'd2;
   localparam logic [ADDR_W-1:0] ADDR_INTR_MASK = 5'd3;
   localparam logic [ADDR_W-1:0] ADDR_INTR_STAT = 5'd4;
   localparam logic [ADDR_W-1:0] ADDR_MFSEL     = 5'd5;
   localparam logic [ADDR_W-1:0] ADDR_RANDOM    = 5'd9;
   localparam logic [ADDR_W-1:0] ADDR_MAILBOX   = 5'd15;
   localparam logic [ADDR_W-1:0] ADDR_SCRATCH_0 = 5'd16;

   // Identity word of manufacturer, core count, chip number and revision
   localparam logic [DATA_W-1:0] CHIP_ID_WORD = {16'h8268, 4'h4, 4'h5, 8'h01};

   // ASCII "RISC"
   localparam logic [DATA_W-1:0] CHIP_SIGNATURE = 32'h5249_5343;
   // Release stamp and project revision words
   localparam logic [DATA_W-1:0] CHIP_RELEASE   = 32'h0100_0000;
   localparam logic [DATA_W-1:0] CHIP_REVISION  = 32'h0005_2000;

   // -------------------------------------------------------------------------
   // Read-write register table in the index order of RW_RESET
   // -------------------------------------------------------------------------
   localparam logic [ADDR_W-1:0] RW_ADDR [NUM_RW] = '{
      ADDR_RST_CTRL, ADDR_CFG, ADDR_INTR_MASK, ADDR_MFSEL, ADDR_MAILBOX,
      ADDR_SCRATCH_0,        ADDR_SCRATCH_0 + 5'd1, ADDR_SCRATCH_0 + 5'd2,
      ADDR_SCRATCH_0 + 5'd3, ADDR_SCRATCH_0 + 5'd4, ADDR_SCRATCH_0 + 5'd5,
      ADDR_SCRATCH_0 + 5'd6, ADDR_SCRATCH_0 + 5'd7
   };

   // Only the CPU interface and QSPI leave reset at power up
   localparam logic [DATA_W-1:0] RW_RESET [NUM_RW] = '{
      32'h0000_0003, 32'h0, 32'h0, 32'h8000_0000, 32'h0,
      CHIP_SIGNATURE, CHIP_RELEASE, CHIP_REVISION,
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0
   };

   // Galois feedback mask and nonzero start value
   localparam logic [DATA_W-1:0] LFSR_TAPS = 32'h8020_0003;
   localparam logic [DATA_W-1:0] LFSR_SEED = 32'h0000_0001;

endpackage

/* hdl/glbl_field_pkg.sv */
package glbl_field_pkg;

   // -------------------------------------------------------------------------
   // Core configuration word, MSB first
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic [15:0] riscv_ctrl;
      logic [6:0]  rsvd_hi;
      // GPIO de-glitch mode select
      logic        gpio_dgmode;
      logic [3:0]  rsvd_lo;
      logic        soft_irq;
      logic [2:0]  user_irq;
   } glbl_cfg_fields_t;

   // Same stored word, raw for read back and decoded for the outputs
   typedef union packed {
      logic [glbl_map_pkg::DATA_W-1:0] raw;
      glbl_cfg_fields_t                f;
   } glbl_cfg_u;

   // -------------------------------------------------------------------------
   // Reset control word
   // -------------------------------------------------------------------------
   // Peripheral resets from bit 0 upward
   // cpu intf, qspi, sspi, uart0, i2cm, usb, uart1
   localparam int RST_CPU_INTF_BIT = 0;
   localparam int RST_PERIPH_W     = 7;

   // One reset per core starting at bit 8
   localparam int RST_CORE_LSB     = 8;
   localparam int NUM_CORES        = 4;

endpackage

/* hdl/glbl_wr_dec.sv */
`timescale 1ns/1ps

module glbl_wr_dec #(
   parameter int NUM_RW = glbl_map_pkg::NUM_RW
) (
   input  logic                            reg_cs,
   input  logic                            reg_wr,
   input  logic [glbl_map_pkg::ADDR_W-1:0] reg_addr,
   output logic [NUM_RW-1:0]               wr_en,
   output logic                            stat_wr
);

   import glbl_map_pkg::*;

   logic bus_wr;

   // Write selected on this cycle
   assign bus_wr = reg_cs & reg_wr;

   // -------------------------------------------------------------------------
   // One strobe per read-write register
   // -------------------------------------------------------------------------
   // Held for as long as the master keeps the write on the bus
   always_comb begin
      for (int i = 0; i < NUM_RW; i++) begin
         wr_en[i] = bus_wr & (reg_addr == RW_ADDR[i]);
      end
   end

   // Status is not in the table
   // W1C handled in the interrupt block
   assign stat_wr = bus_wr & (reg_addr == ADDR_INTR_STAT);

endmodule

/* hdl/glbl_rw_reg.sv */
`timescale 1ns/1ps

module glbl_rw_reg #(
   parameter logic [glbl_map_pkg::DATA_W-1:0] RESET_VAL = '0
) (
   input  logic                            mclk,
   input  logic                            s_reset_n,
   input  logic                            wr_en,
   input  logic [glbl_map_pkg::BE_W-1:0]   be,
   input  logic [glbl_map_pkg::DATA_W-1:0] wdata,
   output logic [glbl_map_pkg::DATA_W-1:0] q
);

   import glbl_map_pkg::*;

   // Byte lanes follow their enable
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (s_reset_n == 1'b0) begin
         q <= RESET_VAL;
      end else if (wr_en) begin
         for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
               q[b*8 +: 8] <= wdata[b*8 +: 8];
            end
         end
      end
   end

endmodule

/* hdl/glbl_intr_ctrl.sv */
`timescale 1ns/1ps

module glbl_intr_ctrl (
   input  logic                            mclk,
   input  logic                            s_reset_n,
   input  logic                            stat_wr,
   input  logic                            reg_ack,
   input  logic [glbl_map_pkg::BE_W-1:0]   be,
   input  logic [glbl_map_pkg::DATA_W-1:0] wdata,
   input  logic [glbl_map_pkg::DATA_W-1:0] mask,
   input  logic                            usb_intr,
   input  logic                            i2cm_intr,
   input  logic                            rtc_intr,
   input  logic                            ir_intr,
   input  logic                            pwm_intr,
   input  logic [2:0]                      timer_intr,
   input  logic [31:0]                     gpio_intr,
   output logic [glbl_map_pkg::DATA_W-1:0] status,
   output logic [glbl_map_pkg::DATA_W-1:0] irq_lines
);

   import glbl_map_pkg::*;

   // Async sources, order ir, rtc, usb, i2cm
   logic [3:0]        async_in;
   logic [3:0]        sync_s;
   logic [3:0]        sync_ss;
   logic [DATA_W-1:0] intr_req;
   logic [DATA_W-1:0] clr_mask;

   assign async_in = {ir_intr, rtc_intr, usb_intr, i2cm_intr};

   // -------------------------------------------------------------------------
   // Double synchronizers
   // -------------------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (s_reset_n == 1'b0) begin
         sync_s  <= '0;
         sync_ss <= '0;
      end else begin
         sync_s  <= async_in;
         sync_ss <= sync_s;
      end
   end

   // GPIO[7:0] is port A, no interrupt from there
   assign intr_req = {gpio_intr[31:8], sync_ss[3], sync_ss[2], pwm_intr,
                      sync_ss[1], sync_ss[0], timer_intr};

   // -------------------------------------------------------------------------
   // Sticky status with W1C
   // -------------------------------------------------------------------------
   // Clear once per transaction, at the ack edge
   always_comb begin
      for (int b = 0; b < BE_W; b++) begin
         clr_mask[b*8 +: 8] = {8{stat_wr & reg_ack & be[b]}} & wdata[b*8 +: 8];
      end
   end

   // Set wins over clear
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (s_reset_n == 1'b0) begin
         status <= '0;
      end else begin
         status <= (status & ~clr_mask) | intr_req;
      end
   end

   assign irq_lines = mask & status;

endmodule

/* hdl/glbl_lfsr.sv */
`timescale 1ns/1ps

module glbl_lfsr (
   input  logic                            mclk,
   input  logic                            s_reset_n,
   input  logic                            step,
   output logic [glbl_map_pkg::DATA_W-1:0] random
);

   import glbl_map_pkg::*;

   logic [DATA_W-1:0] feedback;
   logic [DATA_W-1:0] random_nxt;

   // Taps folded in when the shifted-out bit is set
   assign feedback   = {DATA_W{random[0]}} & LFSR_TAPS;
   assign random_nxt = (random >> 1) ^ feedback;

   // One step per bus acknowledge
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (s_reset_n == 1'b0) begin
         random <= LFSR_SEED;
      end else if (step) begin
         random <= random_nxt;
      end
   end

endmodule

/* hdl/glbl_rd_resp.sv */
`timescale 1ns/1ps

module glbl_rd_resp #(
   parameter int NUM_RW = glbl_map_pkg::NUM_RW
) (
   input  logic                                        mclk,
   input  logic                                        s_reset_n,
   input  logic                                        reg_cs,
   input  logic [glbl_map_pkg::ADDR_W-1:0]             reg_addr,
   input  logic [NUM_RW-1:0][glbl_map_pkg::DATA_W-1:0] rw_q,
   input  logic [glbl_map_pkg::DATA_W-1:0]             status,
   input  logic [glbl_map_pkg::DATA_W-1:0]             random,
   output logic [glbl_map_pkg::DATA_W-1:0]             reg_rdata,
   output logic                                        reg_ack
);

   import glbl_map_pkg::*;

   logic [DATA_W-1:0] rd_mux;
   logic              rd_take;

   // -------------------------------------------------------------------------
   // Read mux
   // -------------------------------------------------------------------------
   // Unmapped addresses read as zero
   always_comb begin
      rd_mux = '0;
      if (reg_addr == ADDR_CHIP_ID) begin
         rd_mux = CHIP_ID_WORD;
      end else if (reg_addr == ADDR_INTR_STAT) begin
         rd_mux = status;
      end else if (reg_addr == ADDR_RANDOM) begin
         rd_mux = random;
      end
      for (int i = 0; i < NUM_RW; i++) begin
         if (reg_addr == RW_ADDR[i]) begin
            rd_mux = rw_q[i];
         end
      end
   end

   // First edge of a held chip select
   assign rd_take = reg_cs & ~reg_ack;

   // Single cycle ack
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (s_reset_n == 1'b0) begin
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= rd_take;
      end
   end

   // Data valid while ack is high
   always_ff @(posedge mclk) begin
      if (rd_take) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

/* hdl/glbl_reg_top.sv */
`timescale 1ns/1ps

module glbl_reg_top #(
   parameter int NUM_RW = glbl_map_pkg::NUM_RW
) (
   input  logic                            mclk,
   input  logic                            s_reset_n,
   // Register bus
   input  logic                            reg_cs,
   input  logic                            reg_wr,
   input  logic [glbl_map_pkg::ADDR_W-1:0] reg_addr,
   input  logic [glbl_map_pkg::DATA_W-1:0] reg_wdata,
   input  logic [glbl_map_pkg::BE_W-1:0]   reg_be,
   output logic [glbl_map_pkg::DATA_W-1:0] reg_rdata,
   output logic                            reg_ack,
   // Interrupt sources
   input  logic                            usb_intr,
   input  logic                            i2cm_intr,
   input  logic                            rtc_intr,
   input  logic                            ir_intr,
   input  logic                            pwm_intr,
   input  logic [2:0]                      timer_intr,
   input  logic [31:0]                     gpio_intr,
   output logic [glbl_map_pkg::DATA_W-1:0] irq_lines,
   // Core configuration
   output logic                            soft_irq,
   output logic [2:0]                      user_irq,
   output logic [15:0]                     cfg_riscv_ctrl,
   output logic                            cfg_gpio_dgmode,
   output logic [glbl_map_pkg::DATA_W-1:0] cfg_multi_func_sel,
   // Active-low reset controls
   output logic                            cpu_intf_rst_n,
   output logic                            qspim_rst_n,
   output logic                            sspim_rst_n,
   output logic                            i2cm_rst_n,
   output logic                            usb_rst_n,
   output logic [1:0]                      uart_rst_n,
   output logic [glbl_field_pkg::NUM_CORES-1:0] cpu_core_rst_n
);

   import glbl_map_pkg::*;
   import glbl_field_pkg::*;

   // Position of an address in the RW table
   function automatic int rw_index(input logic [ADDR_W-1:0] addr);
      int idx;
      idx = 0;
      for (int i = 0; i < NUM_RW; i++) begin
         if (RW_ADDR[i] == addr) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   localparam int IDX_RST_CTRL = rw_index(ADDR_RST_CTRL);
   localparam int IDX_CFG      = rw_index(ADDR_CFG);
   localparam int IDX_MASK     = rw_index(ADDR_INTR_MASK);
   localparam int IDX_MFSEL    = rw_index(ADDR_MFSEL);

   logic [NUM_RW-1:0]             wr_en;
   logic                          stat_wr;
   logic [NUM_RW-1:0][DATA_W-1:0] rw_q;
   logic [DATA_W-1:0]             status;
   logic [DATA_W-1:0]             random;
   logic [RST_PERIPH_W-1:0]       periph_rst;
   glbl_cfg_u                     cfg_word;

   // -------------------------------------------------------------------------
   // Write decode and RW register array
   // -------------------------------------------------------------------------
   glbl_wr_dec #(.NUM_RW(NUM_RW)) u_wr_dec (
      .reg_cs   (reg_cs),
      .reg_wr   (reg_wr),
      .reg_addr (reg_addr),
      .wr_en    (wr_en),
      .stat_wr  (stat_wr)
   );

   for (genvar g = 0; g < NUM_RW; g++) begin : g_rw
      glbl_rw_reg #(.RESET_VAL(RW_RESET[g])) u_rw_reg (
         .mclk      (mclk),
         .s_reset_n (s_reset_n),
         .wr_en     (wr_en[g]),
         .be        (reg_be),
         .wdata     (reg_wdata),
         .q         (rw_q[g])
      );
   end

   // Interrupt status and masking
   glbl_intr_ctrl u_intr_ctrl (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .stat_wr    (stat_wr),
      .reg_ack    (reg_ack),
      .be         (reg_be),
      .wdata      (reg_wdata),
      .mask       (rw_q[IDX_MASK]),
      .usb_intr   (usb_intr),
      .i2cm_intr  (i2cm_intr),
      .rtc_intr   (rtc_intr),
      .ir_intr    (ir_intr),
      .pwm_intr   (pwm_intr),
      .timer_intr (timer_intr),
      .gpio_intr  (gpio_intr),
      .status     (status),
      .irq_lines  (irq_lines)
   );

   // Random number advanced by every ack
   glbl_lfsr u_lfsr (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .step      (reg_ack),
      .random    (random)
   );

   glbl_rd_resp #(.NUM_RW(NUM_RW)) u_rd_resp (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .reg_cs    (reg_cs),
      .reg_addr  (reg_addr),
      .rw_q      (rw_q),
      .status    (status),
      .random    (random),
      .reg_rdata (reg_rdata),
      .reg_ack   (reg_ack)
   );

   // -------------------------------------------------------------------------
   // Field decode
   // -------------------------------------------------------------------------
   assign cfg_word.raw       = rw_q[IDX_CFG];
   assign soft_irq           = cfg_word.f.soft_irq;
   assign user_irq           = cfg_word.f.user_irq;
   assign cfg_riscv_ctrl     = cfg_word.f.riscv_ctrl;
   assign cfg_gpio_dgmode    = cfg_word.f.gpio_dgmode;
   assign cfg_multi_func_sel = rw_q[IDX_MFSEL];

   // Peripheral resets with bit 7 left unused
   assign periph_rst     = rw_q[IDX_RST_CTRL][RST_CPU_INTF_BIT +: RST_PERIPH_W];
   assign cpu_intf_rst_n = periph_rst[0];
   assign qspim_rst_n    = periph_rst[1];
   assign sspim_rst_n    = periph_rst[2];
   assign uart_rst_n[0]  = periph_rst[3];
   assign i2cm_rst_n     = periph_rst[4];
   assign usb_rst_n      = periph_rst[5];
   assign uart_rst_n[1]  = periph_rst[6];
   assign cpu_core_rst_n = rw_q[IDX_RST_CTRL][RST_CORE_LSB +: NUM_CORES];

endmodule

/* tb/glbl_reg_asserts.sv */
`timescale 1ns/1ps

module glbl_reg_asserts (
   input  logic                            mclk,
   input  logic                            s_reset_n,
   input  logic                            reg_cs,
   input  logic                            reg_ack,
   input  logic [glbl_map_pkg::DATA_W-1:0] irq_lines,
   input  logic [glbl_map_pkg::DATA_W-1:0] mask
);

   // Read back by the testbench at the end of the run
   int assert_fails = 0;

   // -------------------------------------------------------------------------
   // Bus acknowledge
   // -------------------------------------------------------------------------
   // Single-cycle pulse only
   ack_single : assert property (@(posedge mclk) disable iff (!s_reset_n)
      reg_ack |=> !reg_ack)
      else begin
         $error("reg_ack stayed high for two cycles");
         assert_fails++;
      end

   // Ack needs chip select in the cycle before
   ack_after_cs : assert property (@(posedge mclk) disable iff (!s_reset_n)
      reg_ack |-> $past(reg_cs))
      else begin
         $error("reg_ack without reg_cs in the previous cycle");
         assert_fails++;
      end

   // Interrupt lines never outside the mask
   irq_in_mask : assert property (@(posedge mclk) disable iff (!s_reset_n)
      (irq_lines & ~mask) == '0)
      else begin
         $error("irq_lines has a bit that is not in the mask");
         assert_fails++;
      end

endmodule

bind glbl_reg_top glbl_reg_asserts u_asserts (
   .mclk      (mclk),
   .s_reset_n (s_reset_n),
   .reg_cs    (reg_cs),
   .reg_ack   (reg_ack),
   .irq_lines (irq_lines),
   .mask      (rw_q[IDX_MASK])
);

/* tb/tb_glbl_reg.sv */
`timescale 1ns/1ps

module tb_glbl_reg;

   import glbl_map_pkg::*;

   localparam int CLK_PERIOD   = 4;
   // Upper bound on bus transactions over the whole run
   localparam int N_TXN        = 150;
   localparam int WATCHDOG_CYC = N_TXN * 20 + 200;
   localparam int ACK_LIMIT    = 10;
   // Manufacturer 0x8268, four cores, chip 5, revision 1
   localparam logic [31:0] EXP_CHIP_ID = 32'h8268_4501;
   localparam logic [4:0] TB_RW_ADDR [13] = '{5'd1, 5'd2, 5'd3, 5'd5, 5'd15,
      5'd16, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21, 5'd22, 5'd23};
   // Read-only and unmapped, status left out since writes clear it
   localparam logic [4:0] NON_RW_ADDR [8] = '{5'd0, 5'd6, 5'd7, 5'd8, 5'd9,
      5'd10, 5'd24, 5'd31};

   logic        mclk;
   logic        s_reset_n;
   logic        reg_cs;
   logic        reg_wr;
   logic [4:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic [3:0]  reg_be;
   logic [31:0] reg_rdata;
   logic        reg_ack;
   logic        usb_intr;
   logic        i2cm_intr;
   logic        rtc_intr;
   logic        ir_intr;
   logic        pwm_intr;
   logic [2:0]  timer_intr;
   logic [31:0] gpio_intr;
   logic [31:0] irq_lines;
   logic        soft_irq;
   logic [2:0]  user_irq;
   logic [15:0] cfg_riscv_ctrl;
   logic        cfg_gpio_dgmode;
   logic [31:0] cfg_multi_func_sel;
   logic        cpu_intf_rst_n;
   logic        qspim_rst_n;
   logic        sspim_rst_n;
   logic        i2cm_rst_n;
   logic        usb_rst_n;
   logic [1:0]  uart_rst_n;
   logic [3:0]  cpu_core_rst_n;

   // Reference model state
   logic [31:0] shadow [32];
   logic [31:0] stat_model;
   logic [31:0] lfsr_model;
   integer      seed;

   // Pending comparisons
   logic [31:0] exp_q [$];
   logic [31:0] act_q [$];
   string       what_q [$];
   event        chk_ev;
   int          n_checks;
   int          n_errors;
   logic [31:0] cmp_exp;
   logic [31:0] cmp_act;
   string       cmp_what;

   glbl_reg_top #(.NUM_RW(NUM_RW)) UUT (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .reg_cs             (reg_cs),
      .reg_wr             (reg_wr),
      .reg_addr           (reg_addr),
      .reg_wdata          (reg_wdata),
      .reg_be             (reg_be),
      .reg_rdata          (reg_rdata),
      .reg_ack            (reg_ack),
      .usb_intr           (usb_intr),
      .i2cm_intr          (i2cm_intr),
      .rtc_intr           (rtc_intr),
      .ir_intr            (ir_intr),
      .pwm_intr           (pwm_intr),
      .timer_intr         (timer_intr),
      .gpio_intr          (gpio_intr),
      .irq_lines          (irq_lines),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_gpio_dgmode    (cfg_gpio_dgmode),
      .cfg_multi_func_sel (cfg_multi_func_sel),
      .cpu_intf_rst_n     (cpu_intf_rst_n),
      .qspim_rst_n        (qspim_rst_n),
      .sspim_rst_n        (sspim_rst_n),
      .i2cm_rst_n         (i2cm_rst_n),
      .usb_rst_n          (usb_rst_n),
      .uart_rst_n         (uart_rst_n),
      .cpu_core_rst_n     (cpu_core_rst_n)
   );

   always #(CLK_PERIOD / 2) mclk = ~mclk;

   // -------------------------------------------------------------------------
   // Reference model
   // -------------------------------------------------------------------------
   function automatic logic is_rw(input logic [4:0] addr);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < 13; i++) begin
         if (TB_RW_ADDR[i] == addr) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   // Right shift, taps folded in when a 1 drops out
   function automatic logic [31:0] lfsr_step(input logic [31:0] v);
      return (v >> 1) ^ (v[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   function automatic logic [31:0] expected_read(input logic [4:0] addr);
      if (addr == 5'd0) begin
         return EXP_CHIP_ID;
      end else if (addr == 5'd4) begin
         return stat_model;
      end else if (addr == 5'd9) begin
         return lfsr_model;
      end else if (is_rw(addr)) begin
         return shadow[addr];
      end
      return 32'h0;
   endfunction

   // Byte-enabled update, W1C on status
   function automatic void apply_write(input logic [4:0] addr, input logic [31:0] data,
                                       input logic [3:0] be);
      for (int b = 0; b < 4; b++) begin
         if (be[b] && is_rw(addr)) begin
            shadow[addr][b*8 +: 8] = data[b*8 +: 8];
         end else if (be[b] && addr == 5'd4) begin
            stat_model[b*8 +: 8] = stat_model[b*8 +: 8] & ~data[b*8 +: 8];
         end
      end
   endfunction

   task automatic init_model();
      for (int a = 0; a < 32; a++) begin
         shadow[a] = 32'h0;
      end
      shadow[1]  = 32'h0000_0003;
      shadow[5]  = 32'h8000_0000;
      // ASCII "RISC", release and revision words
      shadow[16] = 32'h5249_5343;
      shadow[17] = CHIP_RELEASE;
      shadow[18] = CHIP_REVISION;
      stat_model = 32'h0;
      lfsr_model = 32'h0000_0001;
   endtask

   // -------------------------------------------------------------------------
   // Compare process
   // -------------------------------------------------------------------------
   task automatic queue_check(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      exp_q.push_back(exp);
      act_q.push_back(act);
      what_q.push_back(what);
      -> chk_ev;
   endtask

   always @(chk_ev) begin
      while (exp_q.size() > 0) begin
         cmp_exp  = exp_q.pop_front();
         cmp_act  = act_q.pop_front();
         cmp_what = what_q.pop_front();
         n_checks++;
         assert (cmp_act === cmp_exp)
         else begin
            $display("** Error at %t: %s expected 0x%08h, got 0x%08h",
                     $time, cmp_what, cmp_exp, cmp_act);
            n_errors++;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Bus tasks
   // -------------------------------------------------------------------------
   // Hold chip select until ack, drop it one cycle later
   task automatic bus_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, output logic [31:0] rdata);
      int wait_cnt;
      wait_cnt = 0;
      @(posedge mclk);
      reg_cs    <= 1'b1;
      reg_wr    <= wr;
      reg_addr  <= addr;
      reg_wdata <= wdata;
      reg_be    <= be;
      do begin
         @(negedge mclk);
         wait_cnt++;
      end while (!reg_ack && wait_cnt < ACK_LIMIT);
      if (!reg_ack) begin
         $display("Bus acknowledge never came for address %0d", addr);
         n_errors++;
      end
      rdata = reg_rdata;
      @(posedge mclk);
      reg_cs <= 1'b0;
      reg_wr <= 1'b0;
      // Every ack advances the random register
      lfsr_model = lfsr_step(lfsr_model);
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
      logic [31:0] unused;
      bus_xfer(1'b1, addr, data, be, unused);
      apply_write(addr, data, be);
   endtask

   task automatic read_check(input logic [4:0] addr);
      logic [31:0] exp;
      logic [31:0] got;
      exp = expected_read(addr);
      bus_xfer(1'b0, addr, 32'h0, 4'h0, got);
      queue_check($sformatf("read of address %0d", addr), exp, got);
   endtask

   // Decoded fields against the shadow words
   task automatic check_outputs();
      logic [31:0] cfg;
      logic [31:0] rst;
      cfg = shadow[2];
      rst = shadow[1];
      @(negedge mclk);
      queue_check("soft_irq", {31'h0, cfg[3]}, {31'h0, soft_irq});
      queue_check("user_irq", {29'h0, cfg[2:0]}, {29'h0, user_irq});
      queue_check("cfg_riscv_ctrl", {16'h0, cfg[31:16]}, {16'h0, cfg_riscv_ctrl});
      queue_check("cfg_gpio_dgmode", {31'h0, cfg[8]}, {31'h0, cfg_gpio_dgmode});
      queue_check("cfg_multi_func_sel", shadow[5], cfg_multi_func_sel);
      queue_check("reset outputs", {21'h0, rst[11:8], rst[6:0]},
                  {21'h0, cpu_core_rst_n, uart_rst_n[1], usb_rst_n, i2cm_rst_n,
                   uart_rst_n[0], sspim_rst_n, qspim_rst_n, cpu_intf_rst_n});
   endtask

   task automatic check_irq();
      @(negedge mclk);
      queue_check("irq_lines", shadow[3] & stat_model, irq_lines);
   endtask

   // One-cycle pulse, then time for the synchronizers and status flop
   task automatic pulse_sources(input logic [2:0] timer, input logic i2cm, input logic usb,
                                input logic pwm, input logic rtc, input logic ir,
                                input logic [31:0] gpio);
      @(posedge mclk);
      timer_intr <= timer;
      i2cm_intr  <= i2cm;
      usb_intr   <= usb;
      pwm_intr   <= pwm;
      rtc_intr   <= rtc;
      ir_intr    <= ir;
      gpio_intr  <= gpio;
      @(posedge mclk);
      timer_intr <= 3'b0;
      i2cm_intr  <= 1'b0;
      usb_intr   <= 1'b0;
      pwm_intr   <= 1'b0;
      rtc_intr   <= 1'b0;
      ir_intr    <= 1'b0;
      gpio_intr  <= 32'h0;
      repeat (4) @(posedge mclk);
      // GPIO 7..0 has no status bit
      stat_model = stat_model | {gpio[31:8], ir, rtc, pwm, usb, i2cm, timer};
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------
   initial begin
      logic [31:0] data;
      logic [3:0]  be;
      $timeformat(-9, 1, " ns", 10);
      seed       = 32'haa7a;
      mclk       = 1'b0;
      s_reset_n  = 1'b0;
      reg_cs     = 1'b0;
      reg_wr     = 1'b0;
      reg_addr   = 5'd0;
      reg_wdata  = 32'h0;
      reg_be     = 4'h0;
      usb_intr   = 1'b0;
      i2cm_intr  = 1'b0;
      rtc_intr   = 1'b0;
      ir_intr    = 1'b0;
      pwm_intr   = 1'b0;
      timer_intr = 3'b0;
      gpio_intr  = 32'h0;
      n_checks   = 0;
      n_errors   = 0;
      init_model();
      repeat (5) @(posedge mclk);
      s_reset_n <= 1'b1;

      // Reset values on every address and on the outputs
      for (int a = 0; a < 32; a++) begin
         read_check(a[4:0]);
      end
      check_outputs();

      // Random byte-enabled writes, two rounds
      for (int r = 0; r < 2; r++) begin
         for (int i = 0; i < 13; i++) begin
            data = $random(seed);
            be   = $random(seed);
            write_reg(TB_RW_ADDR[i], data, be);
            read_check(TB_RW_ADDR[i]);
         end
      end
      // Read-only and unmapped writes leave everything alone
      for (int i = 0; i < 8; i++) begin
         data = $random(seed);
         write_reg(NON_RW_ADDR[i], data, 4'hF);
      end
      for (int a = 0; a < 32; a++) begin
         read_check(a[4:0]);
      end

      // Configuration and reset-control fields
      data = $random(seed);
      write_reg(ADDR_CFG, data, 4'hF);
      check_outputs();
      write_reg(ADDR_RST_CTRL, 32'h0000_0A55, 4'hF);
      check_outputs();
      data = $random(seed);
      write_reg(ADDR_RST_CTRL, data, 4'b0010);
      check_outputs();

      // Interrupt status, mask and W1C
      data = $random(seed);
      write_reg(ADDR_INTR_MASK, data, 4'hF);
      pulse_sources(3'b010, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 32'h8000_0108);
      read_check(ADDR_INTR_STAT);
      check_irq();
      pulse_sources(3'b100, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0001_0000);
      read_check(ADDR_INTR_STAT);
      check_irq();
      // Low byte only
      write_reg(ADDR_INTR_STAT, 32'hFFFF_FFFF, 4'b0001);
      read_check(ADDR_INTR_STAT);
      check_irq();
      write_reg(ADDR_INTR_STAT, 32'h8000_0000, 4'hF);
      read_check(ADDR_INTR_STAT);
      check_irq();
      write_reg(ADDR_INTR_MASK, 32'hFFFF_FFFF, 4'hF);
      check_irq();

      // LFSR sequence, one step per access
      read_check(ADDR_RANDOM);
      read_check(ADDR_RANDOM);
      read_check(ADDR_RANDOM);
      data = $random(seed);
      write_reg(ADDR_MAILBOX, data, 4'hF);
      read_check(ADDR_RANDOM);
      read_check(ADDR_MAILBOX);
      read_check(ADDR_RANDOM);

      repeat (2) @(posedge mclk);
      -> chk_ev;
      #1;
      $display("Checks: %0d, value errors: %0d, assertion failures: %0d, unchecked: %0d",
               n_checks, n_errors, UUT.u_asserts.assert_fails, exp_q.size());
      if (n_errors == 0 && UUT.u_asserts.assert_fails == 0 && exp_q.size() == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Watchdog sized from the transaction budget
   initial begin
      repeat (WATCHDOG_CYC) @(posedge mclk);
      $display("Watchdog expired before the test sequence finished");
      $display("Some tests failed");
      $finish;
   end

endmodule

/* verilog.f */
hdl/glbl_map_pkg.sv
hdl/glbl_field_pkg.sv
hdl/glbl_wr_dec.sv
hdl/glbl_rw_reg.sv
hdl/glbl_intr_ctrl.sv
hdl/glbl_lfsr.sv
hdl/glbl_rd_resp.sv
hdl/glbl_reg_top.sv
tb/glbl_reg_asserts.sv
tb/tb_glbl_reg.sv
